//--- hw/hazardPkg.sv
`default_nettype none

package hazardPkg;

  // Register number, r0 to r15
  typedef logic [3:0] regAddrT;

  // Execute-stage operand source select
  typedef logic [1:0] fwdSelT;

  // Exception vector offset select for the PC input mux
  typedef logic [1:0] pcSelT;

  // Operand from the register file read in decode
  localparam fwdSelT FWD_NONE = 2'd0;
  // Operand from the writeback result
  localparam fwdSelT FWD_WB = 2'd1;
  // Operand from the memory stage ALU result
  localparam fwdSelT FWD_MEM = 2'd2;

  // Vector entered with no offset
  localparam pcSelT PC_SEL_ZERO = 2'd0;
  // Undefined instruction vector
  localparam pcSelT PC_SEL_UNDEF = 2'd1;
  // Vector taken with the saved return address
  localparam pcSelT PC_SEL_SAVED = 2'd2;

  // Program counter, its reads come from the fetch path and never forward
  localparam regAddrT PC_REG = 4'd15;

endpackage

`default_nettype wire

//--- hw/fwdUnit.sv
`default_nettype none

module fwdUnit import hazardPkg::*; (
  // Decode stage sources checked for load-use
  input  regAddrT src1D,
  input  regAddrT src2D,
  // Execute stage sources checked for forwarding
  input  regAddrT src1E,
  input  regAddrT src2E,
  // Destinations further down the pipe
  input  regAddrT destE,
  input  regAddrT destM,
  input  regAddrT destW,
  input  logic    regWriteM,
  input  logic    regWriteW,
  input  logic    memToRegE,
  // Micro-op sequencer for LDM/STM wants the address from memory
  input  logic    ldmStmFwdE,
  output fwdSelT  forwardAE,
  output fwdSelT  forwardBE,
  output logic    incrementE,
  output logic    ldrStallD
);

  logic hit1M;
  logic hit1W;
  logic hit2M;
  logic hit2W;

  // Match against a later stage that really writes and never for the PC
  function automatic logic srcHit(regAddrT src, regAddrT dest, logic wrEn);
    srcHit = wrEn && (src == dest) && (src != PC_REG);
  endfunction

  assign hit1M = srcHit(src1E, destM, regWriteM);
  assign hit1W = srcHit(src1E, destW, regWriteW);
  assign hit2M = srcHit(src2E, destM, regWriteM);
  assign hit2W = srcHit(src2E, destW, regWriteW);

  // Operand A prefers the nearer stage with the newer value
  always_comb begin
    if (hit1M || ldmStmFwdE) begin
      // LDM/STM base update is forced regardless of the address compare
      forwardAE = FWD_MEM;
    end else if (hit1W) begin
      forwardAE = FWD_WB;
    end else begin
      forwardAE = FWD_NONE;
    end
  end

  // Operand B uses the same ranking without the micro-op override
  always_comb begin
    if (hit2M) begin
      forwardBE = FWD_MEM;
    end else if (hit2W) begin
      forwardBE = FWD_WB;
    end else begin
      forwardBE = FWD_NONE;
    end
  end

  // Address increment step runs with the LDM/STM forward
  assign incrementE = ldmStmFwdE;

  // A load in execute has no data before memory
  // so a dependent instruction in decode has to wait one cycle
  assign ldrStallD = memToRegE && ((src1D == destE) || (src2D == destE));

endmodule

`default_nettype wire

//--- hw/excTracker.sv
`default_nettype none

module excTracker import hazardPkg::*; (
  input  logic  clk,
  input  logic  arstN,
  // Decoder flags for the instruction now in decode
  input  logic  swiD,
  input  logic  undefD,
  // CPSR write in flight, handled like a serializing instruction
  input  logic  regToCpsr,
  // Exception sources at the vector mux
  input  logic  prefetchAbort,
  input  logic  dataAbort,
  input  logic  irq,
  input  logic  fiq,
  input  logic  undefinedInstr,
  input  logic  swi,
  // Final stage controls fed back from stageCtrl
  input  logic  stallE,
  input  logic  stallM,
  input  logic  stallW,
  input  logic  flushE,
  input  logic  flushW,
  output logic  excD,
  output logic  excE,
  output logic  excM,
  output logic  excW,
  output logic  regToCpsrOut,
  output logic  exceptionSavePc,
  output pcSelT pcInSelect
);

  // Swi flag beside the execute marker
  logic swiE;

  // A swi or undefined instruction in decode starts a marker
  assign excD = swiD || undefD;

  // Execute stage where a flush wins over a stall
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      excE <= 1'b0;
      swiE <= 1'b0;
    end else if (flushE) begin
      excE <= 1'b0;
      swiE <= 1'b0;
    end else if (!stallE) begin
      excE <= excD;
      swiE <= swiD;
    end
  end

  // Memory stage only holds on a stall
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      excM <= 1'b0;
    end else if (!stallM) begin
      excM <= excE;
    end
  end

  // Writeback stage
  // a stall keeps the marker even when the flush is up
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      excW <= 1'b0;
    end else if (!stallW) begin
      if (flushW) begin
        excW <= 1'b0;
      end else begin
        excW <= excM;
      end
    end
  end

  // Link register capture for the swi return address
  assign exceptionSavePc = swiE;

  assign regToCpsrOut = regToCpsr;

  // Vector offset with the highest priority first
  always_comb begin
    if (prefetchAbort) begin
      pcInSelect = PC_SEL_ZERO;
    end else if (dataAbort) begin
      pcInSelect = PC_SEL_SAVED;
    end else if (irq || fiq) begin
      pcInSelect = PC_SEL_ZERO;
    end else if (undefinedInstr) begin
      pcInSelect = PC_SEL_UNDEF;
    end else if (swi) begin
      // The return move runs one cycle late down the pipe
      pcInSelect = PC_SEL_SAVED;
    end else begin
      pcInSelect = PC_SEL_ZERO;
    end
  end

  // A held execute marker would otherwise be copied into memory
  assert property (@(posedge clk) disable iff (!arstN)
    stallE |-> stallM)
    else $error("execute stalled while memory advances");

  // Same for a held memory marker and writeback
  assert property (@(posedge clk) disable iff (!arstN)
    stallM |-> stallW)
    else $error("memory stalled while writeback advances");

endmodule

`default_nettype wire

//--- hw/stageCtrl.sv
`default_nettype none

module stageCtrl (
  // Load-use hazard from the comparators
  input  logic ldrStallD,
  // Exception markers per stage
  input  logic excD,
  input  logic excE,
  input  logic excM,
  input  logic excW,
  input  logic regToCpsr,
  // Cache misses
  input  logic dStall,
  input  logic iStall,
  // Multi-cycle multiply and micro-op sequencing
  input  logic multStallD,
  input  logic uOpStallD,
  // PC write or taken branch in flight
  input  logic pcWrPendingF,
  input  logic pcSrcW,
  input  logic branchTakenE,
  output logic stallF,
  output logic stallD,
  output logic stallE,
  output logic stallM,
  output logic stallW,
  output logic flushD,
  output logic flushE,
  output logic flushW,
  output logic stallUop
);

  logic memStall;

  // Either cache miss freezes the whole pipe
  assign memStall = dStall || iStall;

  // Decode holds for load-use, memory, multiply and micro-ops
  // and while an exception marker sits in execute
  assign stallD = ldrStallD || memStall || uOpStallD || multStallD || excE;

  // Micro-op sequencer waits for the same hazards except its own
  assign stallUop = ldrStallD || memStall || multStallD;

  // Fetch holds whenever decode does and also for PC writes
  // and the early exception markers
  assign stallF = ldrStallD || pcWrPendingF || memStall || uOpStallD || multStallD ||
                  excD || excE || excM || regToCpsr;

  // Back half of the pipe only stops on a memory stall
  assign stallE = memStall;
  assign stallM = memStall;
  assign stallW = memStall;
  // Writeback drops its result during a miss
  assign flushW = memStall;

  // Bubble into execute behind a held decode or a wrong path
  assign flushE = ldrStallD || branchTakenE || excM;

  // Decode gets a bubble while fetch has nothing valid
  // an instruction miss leaves decode empty
  assign flushD = pcWrPendingF || pcSrcW || branchTakenE || iStall ||
                  excE || excM || excW || regToCpsr;

endmodule

`default_nettype wire

//--- hw/hazardCtrl.sv
`default_nettype none

module hazardCtrl import hazardPkg::*; (
  input  logic    clk,
  input  logic    arstN,
  input  regAddrT src1D,
  input  regAddrT src2D,
  input  regAddrT src1E,
  input  regAddrT src2E,
  input  regAddrT destE,
  input  regAddrT destM,
  input  regAddrT destW,
  input  logic    regWriteM,
  input  logic    regWriteW,
  input  logic    memToRegE,
  input  logic    ldmStmFwdE,
  input  logic    dStall,
  input  logic    iStall,
  input  logic    multStallD,
  input  logic    uOpStallD,
  input  logic    pcWrPendingF,
  input  logic    pcSrcW,
  input  logic    branchTakenE,
  input  logic    swiD,
  input  logic    undefD,
  input  logic    regToCpsr,
  input  logic    prefetchAbort,
  input  logic    dataAbort,
  input  logic    irq,
  input  logic    fiq,
  input  logic    undefinedInstr,
  input  logic    swi,
  output fwdSelT  forwardAE,
  output fwdSelT  forwardBE,
  output logic    incrementE,
  output logic    stallF,
  output logic    stallD,
  output logic    stallE,
  output logic    stallM,
  output logic    stallW,
  output logic    flushD,
  output logic    flushE,
  output logic    flushW,
  output logic    stallUop,
  output logic    exceptionSavePc,
  output pcSelT   pcInSelect
);

  logic ldrStallD;
  logic excD;
  logic excE;
  logic excM;
  logic excW;
  // CPSR write as seen by the stage controls
  logic cpsrHold;

  fwdUnit u_fwdUnit (
    .src1D      (src1D),
    .src2D      (src2D),
    .src1E      (src1E),
    .src2E      (src2E),
    .destE      (destE),
    .destM      (destM),
    .destW      (destW),
    .regWriteM  (regWriteM),
    .regWriteW  (regWriteW),
    .memToRegE  (memToRegE),
    .ldmStmFwdE (ldmStmFwdE),
    .forwardAE  (forwardAE),
    .forwardBE  (forwardBE),
    .incrementE (incrementE),
    .ldrStallD  (ldrStallD)
  );

  // Marker pipe sees the final stalls, registers only
  excTracker u_excTracker (
    .clk             (clk),
    .arstN           (arstN),
    .swiD            (swiD),
    .undefD          (undefD),
    .regToCpsr       (regToCpsr),
    .prefetchAbort   (prefetchAbort),
    .dataAbort       (dataAbort),
    .irq             (irq),
    .fiq             (fiq),
    .undefinedInstr  (undefinedInstr),
    .swi             (swi),
    .stallE          (stallE),
    .stallM          (stallM),
    .stallW          (stallW),
    .flushE          (flushE),
    .flushW          (flushW),
    .excD            (excD),
    .excE            (excE),
    .excM            (excM),
    .excW            (excW),
    .regToCpsrOut    (cpsrHold),
    .exceptionSavePc (exceptionSavePc),
    .pcInSelect      (pcInSelect)
  );

  stageCtrl u_stageCtrl (
    .ldrStallD    (ldrStallD),
    .excD         (excD),
    .excE         (excE),
    .excM         (excM),
    .excW         (excW),
    .regToCpsr    (cpsrHold),
    .dStall       (dStall),
    .iStall       (iStall),
    .multStallD   (multStallD),
    .uOpStallD    (uOpStallD),
    .pcWrPendingF (pcWrPendingF),
    .pcSrcW       (pcSrcW),
    .branchTakenE (branchTakenE),
    .stallF       (stallF),
    .stallD       (stallD),
    .stallE       (stallE),
    .stallM       (stallM),
    .stallW       (stallW),
    .flushD       (flushD),
    .flushE       (flushE),
    .flushW       (flushW),
    .stallUop     (stallUop)
  );

endmodule

`default_nettype wire

//--- verification/tbClock.sv
`default_nettype none

module tbClock (
  output logic clk,
  output logic arstN
);

  // Period of 10 time units
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset held for two rising edges, released away from the edge
  initial begin
    arstN = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
  end

endmodule

`default_nettype wire

//--- verification/hazardChecker.sv
`default_nettype none

module hazardChecker import hazardPkg::*; (
  input logic    clk,
  input logic    arstN,
  input regAddrT src1D, src2D, src1E, src2E, destE, destM, destW,
  input logic    regWriteM, regWriteW, memToRegE, ldmStmFwdE,
  input logic    dStall, iStall, multStallD, uOpStallD,
  input logic    pcWrPendingF, pcSrcW, branchTakenE, swiD, undefD, regToCpsr,
  input logic    prefetchAbort, dataAbort, irq, fiq, undefinedInstr, swi,
  input fwdSelT  forwardAE, forwardBE,
  input logic    incrementE, stallF, stallD, stallE, stallM, stallW,
  input logic    flushD, flushE, flushW, stallUop, exceptionSavePc,
  input pcSelT   pcInSelect
);

  int errCount = 0;
  // Own copy of the marker pipe
  logic mE;
  logic mM;
  logic mW;
  logic mSwiE;
  logic ldrExp;
  logic [8:0] stageExp;

  // Nearer stage wins and the write enable gates the match
  // The PC never forwards
  function automatic fwdSelT fwdRef(regAddrT src, logic ldm);
    if (ldm || (regWriteM && src == destM && src != PC_REG)) return FWD_MEM;
    if (regWriteW && src == destW && src != PC_REG) return FWD_WB;
    return FWD_NONE;
  endfunction

  // Order is stallF stallD stallE stallM stallW flushD flushE flushW stallUop
  function automatic logic [8:0] stageRef(logic ldr, logic eD);
    logic mem;
    mem = dStall || iStall;
    stageRef[8] = ldr || pcWrPendingF || mem || uOpStallD || multStallD ||
                  eD || mE || mM || regToCpsr;
    stageRef[7] = ldr || mem || uOpStallD || multStallD || mE;
    stageRef[6:4] = {3{mem}};
    stageRef[3] = pcWrPendingF || pcSrcW || branchTakenE || iStall ||
                  mE || mM || mW || regToCpsr;
    stageRef[2] = ldr || branchTakenE || mM;
    stageRef[1] = mem;
    stageRef[0] = ldr || mem || multStallD;
  endfunction

  // Exception vector ranking
  function automatic pcSelT vecRef();
    if (prefetchAbort) return PC_SEL_ZERO;
    if (dataAbort) return PC_SEL_SAVED;
    if (irq || fiq) return PC_SEL_ZERO;
    if (undefinedInstr) return PC_SEL_UNDEF;
    if (swi) return PC_SEL_SAVED;
    return PC_SEL_ZERO;
  endfunction

  task automatic checkVal(string name, int got, int exp);
    if (got != exp) begin
      errCount++;
      $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  // Markers advance from the stalls and flushes seen before the edge
  always @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mE <= 1'b0;
      mM <= 1'b0;
      mW <= 1'b0;
      mSwiE <= 1'b0;
    end else begin
      if (flushE) begin
        mE <= 1'b0;
        mSwiE <= 1'b0;
      end else if (!stallE) begin
        mE <= swiD || undefD;
        mSwiE <= swiD;
      end
      if (!stallM) mM <= mE;
      if (!stallW) mW <= flushW ? 1'b0 : mM;
    end
  end

  // Inputs change on the falling edge and outputs settle shortly after
  always @(negedge clk) begin
    #2;
    if (arstN) begin
      ldrExp = memToRegE && (src1D == destE || src2D == destE);
      stageExp = stageRef(ldrExp, swiD || undefD);
      checkVal("forwardAE", int'(forwardAE), int'(fwdRef(src1E, ldmStmFwdE)));
      checkVal("forwardBE", int'(forwardBE), int'(fwdRef(src2E, 1'b0)));
      checkVal("incrementE", int'(incrementE), int'(ldmStmFwdE));
      checkVal("stallF", int'(stallF), int'(stageExp[8]));
      checkVal("stallD", int'(stallD), int'(stageExp[7]));
      checkVal("stallE", int'(stallE), int'(stageExp[6]));
      checkVal("stallM", int'(stallM), int'(stageExp[5]));
      checkVal("stallW", int'(stallW), int'(stageExp[4]));
      checkVal("flushD", int'(flushD), int'(stageExp[3]));
      checkVal("flushE", int'(flushE), int'(stageExp[2]));
      checkVal("flushW", int'(flushW), int'(stageExp[1]));
      checkVal("stallUop", int'(stallUop), int'(stageExp[0]));
      checkVal("exceptionSavePc", int'(exceptionSavePc), int'(mSwiE));
      checkVal("pcInSelect", int'(pcInSelect), int'(vecRef()));
    end
  end

endmodule

`default_nettype wire

//--- verification/hazardTb.sv
`default_nettype none

module hazardTb import hazardPkg::*;;

  localparam int CYCLE_LIMIT = 2000;

  logic clk;
  logic arstN;
  regAddrT src1D, src2D, src1E, src2E, destE, destM, destW;
  logic regWriteM, regWriteW, memToRegE, ldmStmFwdE;
  logic dStall, iStall, multStallD, uOpStallD;
  logic pcWrPendingF, pcSrcW, branchTakenE, swiD, undefD, regToCpsr;
  logic prefetchAbort, dataAbort, irq, fiq, undefinedInstr, swi;
  fwdSelT forwardAE, forwardBE;
  logic incrementE, stallF, stallD, stallE, stallM, stallW;
  logic flushD, flushE, flushW, stallUop, exceptionSavePc;
  pcSelT pcInSelect;

  integer seed = 11;
  logic [31:0] rnd;
  int cycles = 0;
  int errMark = 0;
  int passedTests = 0;
  int failedTests = 0;

  tbClock u_clk (.clk(clk), .arstN(arstN));
  hazardCtrl i_dut (.*);
  hazardChecker u_chk (.*);

  task automatic clearInputs();
    {src1D, src2D, src1E, src2E, destE, destM, destW} = '0;
    {regWriteM, regWriteW, memToRegE, ldmStmFwdE} = '0;
    {dStall, iStall, multStallD, uOpStallD} = '0;
    {pcWrPendingF, pcSrcW, branchTakenE, swiD, undefD, regToCpsr} = '0;
    {prefetchAbort, dataAbort, irq, fiq, undefinedInstr, swi} = '0;
  endtask

  // Next falling edge, where inputs change
  task automatic nextCycle(int n = 1);
    repeat (n) @(negedge clk);
  endtask

  task automatic setFwd(regAddrT s1, regAddrT s2, regAddrT dm, regAddrT dw,
                        logic wm, logic ww, logic ldm);
    nextCycle();
    clearInputs();
    src1E = s1;
    src2E = s2;
    destM = dm;
    destW = dw;
    regWriteM = wm;
    regWriteW = ww;
    ldmStmFwdE = ldm;
  endtask

  // Settles the last cycle, then reports the test
  task automatic finishTest(string name);
    nextCycle();
    clearInputs();
    nextCycle();
    if (u_chk.errCount == errMark) begin
      passedTests++;
      $display("Test %s: pass", name);
    end else begin
      failedTests++;
      $display("Test %s: fail, %0d mismatches", name, u_chk.errCount - errMark);
    end
    errMark = u_chk.errCount;
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    clearInputs();
    wait (arstN);
    nextCycle();
    // Memory over writeback, PC, gating, LDM/STM override
    setFwd(4'd3, 4'd4, 4'd3, 4'd3, 1'b1, 1'b1, 1'b0);
    setFwd(4'd3, 4'd4, 4'd4, 4'd4, 1'b1, 1'b1, 1'b0);
    setFwd(4'd15, 4'd15, 4'd15, 4'd15, 1'b1, 1'b1, 1'b0);
    setFwd(4'd3, 4'd4, 4'd3, 4'd4, 1'b0, 1'b0, 1'b0);
    setFwd(4'd3, 4'd4, 4'd3, 4'd4, 1'b0, 1'b1, 1'b0);
    setFwd(4'd1, 4'd2, 4'd9, 4'd9, 1'b0, 1'b0, 1'b1);
    repeat (200) begin
      rnd = $random(seed);
      setFwd(rnd[3:0], rnd[7:4], rnd[11:8], rnd[15:12], rnd[16], rnd[17], rnd[18]);
    end
    finishTest("forwarding");

    memToRegE = 1'b1;
    destE = 4'd5;
    src1D = 4'd5;
    nextCycle();
    src1D = 4'd1;
    src2D = 4'd5;
    nextCycle();
    src2D = 4'd2;
    finishTest("load-use");

    dStall = 1'b1;
    nextCycle(2);
    dStall = 1'b0;
    iStall = 1'b1;
    nextCycle(2);
    finishTest("memory stalls");

    branchTakenE = 1'b1;
    nextCycle();
    clearInputs();
    pcSrcW = 1'b1;
    nextCycle();
    clearInputs();
    pcWrPendingF = 1'b1;
    nextCycle();
    clearInputs();
    regToCpsr = 1'b1;
    finishTest("control flow");

    // Free run of a swi and an undefined marker
    swiD = 1'b1;
    nextCycle();
    swiD = 1'b0;
    nextCycle(4);
    undefD = 1'b1;
    nextCycle();
    undefD = 1'b0;
    nextCycle(4);
    // Marker held in a memory stall
    swiD = 1'b1;
    nextCycle();
    swiD = 1'b0;
    dStall = 1'b1;
    nextCycle(3);
    dStall = 1'b0;
    nextCycle(4);
    // Marker dropped by a flush in the same cycle
    swiD = 1'b1;
    branchTakenE = 1'b1;
    nextCycle();
    clearInputs();
    nextCycle(3);
    finishTest("exception markers");

    repeat (200) begin
      rnd = $random(seed);
      {prefetchAbort, dataAbort, irq, fiq, undefinedInstr, swi} = rnd[5:0];
      nextCycle();
    end
    finishTest("vector priority");

    $display("Tests passed %0d, failed %0d, mismatches %0d",
             passedTests, failedTests, u_chk.errCount);
    if (failedTests == 0 && u_chk.errCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
hw/hazardPkg.sv
hw/fwdUnit.sv
hw/excTracker.sv
hw/stageCtrl.sv
hw/hazardCtrl.sv
verification/tbClock.sv
verification/hazardChecker.sv
verification/hazardTb.sv

//--- run.sh
#!/bin/sh
# Build and run with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module hazardTb -f list.f -o hazardSim > sim.log 2>&1 \
  && ./obj_dir/hazardSim >> sim.log 2>&1 \
  || echo "build or simulation failed" >> sim.log
grep -q "Result: PASSED" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }
